/* Makefile */
# Verilator build and run for the pipeline trace unit
# override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TB_TOP    ?= tb_pipe_trace_unit
RTL_TOP   ?= pipe_trace_unit
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cycle_counter.sv */
////////////////////
// cycle counter
// free-running wrap-around time base for the stage stamps
////////////////////

`timescale 1ns/1ps

module cycle_counter #(
    parameter int CYCLE_W = 16
) (
    input  logic               clk,
    input  logic               rst,
    output logic [CYCLE_W-1:0] now
);

    // zero in the first cycle after reset, then one step per clock
    // wraps silently, stamps are compared modulo 2^CYCLE_W
    always_ff @(posedge clk) begin
        if (rst) begin
            now <= '0;
        end else begin
            now <= now + 1'b1;
        end
    end

endmodule

/* filelist.f */
trace_pkg.sv
cycle_counter.sv
trace_ctrl_fsm.sv
stage_tracker.sv
trace_table.sv
trace_fifo.sv
pipe_trace_unit.sv
tb_pipe_trace_unit.sv

/* pipe_trace_unit.sv */
////////////////////
// pipeline trace unit, top level
// stamps each instruction's stage entries and emits one
// record per completed instruction
////////////////////

`timescale 1ns/1ps

module pipe_trace_unit import trace_pkg::*; #(
    parameter int ID_W       = 3,
    parameter int CYCLE_W    = 16,
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               trace_en,
    input  logic               fetch_valid,
    input  logic [instr_w-1:0] fetch_instr,
    input  logic               stall,
    input  logic               flush,
    output logic               rec_valid,
    input  logic               rec_ready,
    output logic [ID_W-1:0]    rec_id,
    output logic [instr_w-1:0] rec_instr,
    output logic [CYCLE_W-1:0] rec_fetch_cycle,
    output logic [CYCLE_W-1:0] rec_decode_cycle,
    output logic [CYCLE_W-1:0] rec_execute_cycle,
    output logic [CYCLE_W-1:0] rec_memory_cycle,
    output logic [CYCLE_W-1:0] rec_wb_cycle,
    output logic [15:0]        drop_count,
    output logic               busy
);

    logic [CYCLE_W-1:0]              now;
    logic                            admit;
    logic                            pipe_empty;
    logic [num_stages-1:0]           stage_valid;
    logic [num_stages-1:0][ID_W-1:0] stage_tag;
    logic                            wb_done;
    logic                            rec_push;
    logic                            fifo_full;
    trace_rec_t                      table_rec;
    trace_rec_t                      fifo_rec;

    cycle_counter #(.CYCLE_W(CYCLE_W)) cycle_counter_i (
        .clk (clk),
        .rst (rst),
        .now (now)
    );

    trace_ctrl_fsm trace_ctrl_fsm_i (
        .clk         (clk),
        .rst         (rst),
        .trace_en    (trace_en),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .pipe_empty  (pipe_empty),
        .rec_push    (rec_push),
        .fifo_full   (fifo_full),
        .admit       (admit),
        .busy        (busy),
        .drop_count  (drop_count)
    );

    stage_tracker #(.ID_W(ID_W)) stage_tracker_i (
        .clk         (clk),
        .rst         (rst),
        .admit       (admit),
        .stall       (stall),
        .flush       (flush),
        .stage_valid (stage_valid),
        .stage_tag   (stage_tag),
        .wb_done     (wb_done),
        .pipe_empty  (pipe_empty)
    );

    trace_table #(.ID_W(ID_W), .CYCLE_W(CYCLE_W)) trace_table_i (
        .clk         (clk),
        .rst         (rst),
        .now         (now),
        .fetch_instr (fetch_instr),
        .stage_valid (stage_valid),
        .stage_tag   (stage_tag),
        .wb_done     (wb_done),
        .rec_push    (rec_push),
        .rec_data    (table_rec)
    );

    trace_fifo #(.DEPTH(FIFO_DEPTH)) trace_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (rec_push),
        .push_data (table_rec),
        .full      (fifo_full),
        .out_valid (rec_valid),
        .out_ready (rec_ready),
        .out_data  (fifo_rec)
    );

    // head record out on loose ports
    assign rec_id            = fifo_rec.id;
    assign rec_instr         = fifo_rec.instr;
    assign rec_fetch_cycle   = fifo_rec.fetch_cycle;
    assign rec_decode_cycle  = fifo_rec.decode_cycle;
    assign rec_execute_cycle = fifo_rec.execute_cycle;
    assign rec_memory_cycle  = fifo_rec.memory_cycle;
    assign rec_wb_cycle      = fifo_rec.wb_cycle;

endmodule

/* stage_tracker.sv */
////////////////////
// stage tracker
// follows instruction tags from fetch to write-back,
// mirroring the core's stall bubble and flush kill
////////////////////

`timescale 1ns/1ps

module stage_tracker import trace_pkg::*; #(
    parameter int ID_W = 3
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             admit,
    input  logic                             stall,
    input  logic                             flush,
    output logic [num_stages-1:0]            stage_valid,
    output logic [num_stages-1:0][ID_W-1:0]  stage_tag,
    output logic                             wb_done,
    output logic                             pipe_empty
);

    // tag handed to the next admitted instruction
    logic [ID_W-1:0] next_tag;

    // registered stages, decode through write-back
    logic [num_stages-1:1]            pipe_valid;
    logic [num_stages-1:1][ID_W-1:0]  pipe_tag;

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag   <= '0;
            pipe_valid <= '0;
        end else begin
            // flushed tags stay consumed
            if (admit) begin
                next_tag <= next_tag + 1'b1;
            end
            // flush wins over stall, decode is killed
            if (flush) begin
                pipe_valid[stg_decode] <= 1'b0;
            end else if (!stall) begin
                pipe_valid[stg_decode] <= admit;
            end
            // bubble on stall, nothing to pass on after a flush
            pipe_valid[stg_execute] <= pipe_valid[stg_decode] && !stall && !flush;
            pipe_valid[stg_memory]  <= pipe_valid[stg_execute];
            pipe_valid[stg_wb]      <= pipe_valid[stg_memory];
        end
    end

    // tags ride along, only qualified by the valid bits
    always_ff @(posedge clk) begin
        if (!stall && !flush) begin
            pipe_tag[stg_decode] <= next_tag;
        end
        pipe_tag[stg_execute] <= pipe_tag[stg_decode];
        pipe_tag[stg_memory]  <= pipe_tag[stg_execute];
        pipe_tag[stg_wb]      <= pipe_tag[stg_memory];
    end

    // fetch is the admission cycle itself
    // admit needs stall low, so fetch never has to hold
    always_comb begin
        stage_valid[stg_fetch]  = admit;
        stage_tag[stg_fetch]    = next_tag;
        for (int s = 1; s < num_stages; s++) begin
            stage_valid[s] = pipe_valid[s];
            stage_tag[s]   = pipe_tag[s];
        end
    end

    // write-back advances every cycle, a valid slot is always a new entry
    assign wb_done    = pipe_valid[stg_wb];
    assign pipe_empty = ~|stage_valid;

endmodule

/* tb_pipe_trace_unit.sv */
////////////////////
// pipeline trace unit testbench
// LCG-driven core activity, a cycle model of the trace rules
// and a per-cycle compare of the DUT outputs
////////////////////

`timescale 1ns/1ps

module tb_pipe_trace_unit import trace_pkg::*; ();

    localparam int id_w       = 3;
    localparam int cycle_w    = 16;
    localparam int fifo_depth = 4;
    localparam int clk_period = 8;
    localparam int num_cycles = 600;

    logic               clk = 1'b0;
    logic               rst;
    logic               trace_en;
    logic               fetch_valid;
    logic [instr_w-1:0] fetch_instr;
    logic               stall;
    logic               flush;
    logic               rec_valid;
    logic               rec_ready;
    logic [id_w-1:0]    rec_id;
    logic [instr_w-1:0] rec_instr;
    logic [cycle_w-1:0] rec_fetch_cycle;
    logic [cycle_w-1:0] rec_decode_cycle;
    logic [cycle_w-1:0] rec_execute_cycle;
    logic [cycle_w-1:0] rec_memory_cycle;
    logic [cycle_w-1:0] rec_wb_cycle;
    logic [15:0]        drop_count;
    logic               busy;

    // stimulus log with one entry per cycle after reset
    bit                 en_log    [num_cycles];
    bit                 fv_log    [num_cycles];
    logic [instr_w-1:0] instr_log [num_cycles];
    bit                 stall_log [num_cycles];
    bit                 flush_log [num_cycles];
    bit                 ready_log [num_cycles];

    // expected outputs per cycle
    bit exp_busy  [num_cycles];
    bit exp_valid [num_cycles];
    int exp_drop  [num_cycles];

    // expected data per instruction by admission order
    logic [instr_w-1:0] seq_word [num_cycles];
    int                 seq_fetch  [num_cycles];
    int                 seq_decode [num_cycles];
    int                 seq_exec   [num_cycles];
    int                 seq_mem    [num_cycles];
    int                 seq_wb     [num_cycles];
    // admission numbers of the records the FIFO should hand out in order
    int                 exp_q [$];

    logic [31:0] seed;
    int          cyc;
    bit          active;

    pipe_trace_unit #(
        .ID_W       (id_w),
        .CYCLE_W    (cycle_w),
        .FIFO_DEPTH (fifo_depth)
    ) pipe_trace_unit_i (
        .clk               (clk),
        .rst               (rst),
        .trace_en          (trace_en),
        .fetch_valid       (fetch_valid),
        .fetch_instr       (fetch_instr),
        .stall             (stall),
        .flush             (flush),
        .rec_valid         (rec_valid),
        .rec_ready         (rec_ready),
        .rec_id            (rec_id),
        .rec_instr         (rec_instr),
        .rec_fetch_cycle   (rec_fetch_cycle),
        .rec_decode_cycle  (rec_decode_cycle),
        .rec_execute_cycle (rec_execute_cycle),
        .rec_memory_cycle  (rec_memory_cycle),
        .rec_wb_cycle      (rec_wb_cycle),
        .drop_count        (drop_count),
        .busy              (busy)
    );

    always #(clk_period / 2) clk = ~clk;

    // linear congruential generator
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic gen_stimulus();
        logic [31:0] r;
        for (int i = 0; i < num_cycles; i++) begin
            r = next_rand();
            instr_log[i] = next_rand();
            // tracing is on in the middle of the run and off at both ends
            en_log[i]    = (i >= 10) && (i < 520);
            fv_log[i]    = 1'b1;
            stall_log[i] = 1'b0;
            flush_log[i] = 1'b0;
            ready_log[i] = 1'b1;
            if (i >= 100 && i < 400) begin
                // issue gaps and stall bursts
                fv_log[i]    = (r[31:30] != 2'b00);
                stall_log[i] = (r[29:28] == 2'b00);
            end
            if (i >= 250 && i < 400) begin
                // flushes that sometimes land on a stall and an uneven consumer
                flush_log[i] = (r[27:25] == 3'b000);
                ready_log[i] = r[24];
            end
            if (i >= 400 && i < 520) begin
                // long back-pressure fills the FIFO so records are lost
                stall_log[i] = (r[23:21] == 3'b000);
                flush_log[i] = (r[20:17] == 4'b0000);
                ready_log[i] = (r[16:14] == 3'b000);
            end
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // replays the stage rules over the logged inputs
    function automatic void build_expected();
        trace_state_t state;
        int nseq;
        int cnt;
        int drops;
        int dseq;
        int eseq;
        int mseq;
        int wseq;
        bit adm;
        bit push;
        bit pop;
        bit empty;
        bit dv;
        bit ev;
        bit mv;
        bit wv;
        state = st_idle;
        nseq  = 0;
        cnt   = 0;
        drops = 0;
        dseq  = 0;
        eseq  = 0;
        mseq  = 0;
        wseq  = 0;
        dv    = 1'b0;
        ev    = 1'b0;
        mv    = 1'b0;
        wv    = 1'b0;
        for (int i = 0; i < num_cycles; i++) begin
            exp_busy[i]  = (state != st_idle);
            exp_valid[i] = (cnt > 0);
            exp_drop[i]  = drops;
            // fetch entry is the cycle the word is offered and taken
            adm = (state == st_run) && fv_log[i] && !stall_log[i];
            if (adm) begin
                seq_word[nseq]  = instr_log[i];
                seq_fetch[nseq] = i;
            end
            // write-back entry is pushed at the end of this cycle
            push = 1'b0;
            if (wv) begin
                seq_wb[wseq] = i;
                if (cnt == fifo_depth) begin
                    drops++;
                end else begin
                    push = 1'b1;
                    exp_q.push_back(wseq);
                end
            end
            pop   = (cnt > 0) && ready_log[i];
            cnt   = cnt + int'(push) - int'(pop);
            empty = !(adm || dv || ev || mv || wv);
            if (state == st_idle && en_log[i]) begin
                state = st_run;
            end else if (state == st_run && !en_log[i]) begin
                state = st_drain;
            end else if (state == st_drain && empty) begin
                state = st_idle;
            end
            // back half of the pipe always moves
            wv   = mv;
            wseq = mseq;
            mv   = ev;
            mseq = eseq;
            if (mv) begin
                seq_mem[mseq] = i + 1;
            end
            // stall leaves a bubble in execute and flush kills decode
            ev   = dv && !stall_log[i] && !flush_log[i];
            eseq = dseq;
            if (ev) begin
                seq_exec[eseq] = i + 1;
            end
            if (flush_log[i]) begin
                dv = 1'b0;
            end else if (!stall_log[i]) begin
                dv   = adm;
                dseq = nseq;
                if (adm) begin
                    seq_decode[nseq] = i + 1;
                end
            end
            if (adm) begin
                nseq++;
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // outputs are settled by mid-cycle
    always @(negedge clk) begin
        int n;
        if (active) begin
            check_value("busy", busy, exp_busy[cyc]);
            check_value("rec_valid", rec_valid, exp_valid[cyc]);
            check_value("drop_count", drop_count, exp_drop[cyc]);
            if (rec_valid && rec_ready) begin
                n = exp_q.pop_front();
                check_value("rec_id", rec_id, n % (1 << id_w));
                check_value("rec_instr", rec_instr, seq_word[n]);
                check_value("rec_fetch_cycle", rec_fetch_cycle, seq_fetch[n] % (1 << cycle_w));
                check_value("rec_decode_cycle", rec_decode_cycle,
                            seq_decode[n] % (1 << cycle_w));
                check_value("rec_execute_cycle", rec_execute_cycle,
                            seq_exec[n] % (1 << cycle_w));
                check_value("rec_memory_cycle", rec_memory_cycle, seq_mem[n] % (1 << cycle_w));
                check_value("rec_wb_cycle", rec_wb_cycle, seq_wb[n] % (1 << cycle_w));
            end
        end
    end

    // watchdog
    initial begin
        #((num_cycles + 100) * clk_period);
        $display("ERROR: simulation timed out before the stimulus finished");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    initial begin
        rst         = 1'b1;
        trace_en    = 1'b0;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        rec_ready   = 1'b0;
        active      = 1'b0;
        cyc         = 0;
        seed        = 32'he2c629f0;
        gen_stimulus();
        build_expected();
        repeat (4) @(posedge clk);
        for (int i = 0; i < num_cycles; i++) begin
            #1;
            rst         = 1'b0;
            active      = 1'b1;
            cyc         = i;
            trace_en    = en_log[i];
            fetch_valid = fv_log[i];
            fetch_instr = instr_log[i];
            stall       = stall_log[i];
            flush       = flush_log[i];
            rec_ready   = ready_log[i];
            @(posedge clk);
        end
        active = 1'b0;
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* trace_ctrl_fsm.sv */
////////////////////
// trace control FSM
// idle/run/drain sequencing, fetch admission into the tracker
// and the saturating count of records lost to a full FIFO
////////////////////

`timescale 1ns/1ps

module trace_ctrl_fsm import trace_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        trace_en,
    input  logic        fetch_valid,
    input  logic        stall,
    input  logic        pipe_empty,
    input  logic        rec_push,
    input  logic        fifo_full,
    output logic        admit,
    output logic        busy,
    output logic [15:0] drop_count
);

    trace_state_t state;
    trace_state_t state_nxt;

    ////////////////////
    // state sequencing
    ////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (trace_en) begin
                    state_nxt = st_run;
                end
            end
            st_run: begin
                // stop admitting, let the in-flight work finish
                if (!trace_en) begin
                    state_nxt = st_drain;
                end
            end
            st_drain: begin
                if (pipe_empty) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // fetch_valid only counts while the front end is moving
    assign admit = (state == st_run) && fetch_valid && !stall;
    assign busy  = (state != st_idle);

    ////////////////////
    // drop counter
    ////////////////////

    // a completing record that meets a full FIFO is lost, count it
    // holds at all ones instead of wrapping
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end else if (rec_push && fifo_full && (drop_count != 16'hffff)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

/* trace_fifo.sv */
////////////////////
// trace record FIFO
// circular buffer, push ignored while full, valid/ready read side
////////////////////

`timescale 1ns/1ps

module trace_fifo import trace_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  trace_rec_t push_data,
    output logic       full,
    output logic       out_valid,
    input  logic       out_ready,
    output trace_rec_t out_data
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    trace_rec_t       mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == cnt_w'(DEPTH));
    assign out_valid = (count != '0);
    // head entry stays put until the handshake
    assign out_data  = mem[rd_ptr];

    // full check uses the current count, a same-cycle pop does not help
    assign do_push = push && !full;
    assign do_pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* trace_pkg.sv */
////////////////////
// pipeline trace shared definitions
// stage indices, record layout and control FSM encoding
////////////////////

package trace_pkg;

    // five-stage in-order core
    localparam int num_stages = 5;
    localparam int instr_w    = 32;

    // stage positions in the valid and tag vectors
    localparam int stg_fetch   = 0;
    localparam int stg_decode  = 1;
    localparam int stg_execute = 2;
    localparam int stg_memory  = 3;
    localparam int stg_wb      = 4;

    // record widths, must match ID_W and CYCLE_W at the top level
    localparam int rec_id_w    = 3;
    localparam int rec_cycle_w = 16;

    // one completed instruction, entry stamp per stage
    typedef struct packed {
        logic [rec_id_w-1:0]    id;
        logic [instr_w-1:0]     instr;
        logic [rec_cycle_w-1:0] fetch_cycle;
        logic [rec_cycle_w-1:0] decode_cycle;
        logic [rec_cycle_w-1:0] execute_cycle;
        logic [rec_cycle_w-1:0] memory_cycle;
        logic [rec_cycle_w-1:0] wb_cycle;
    } trace_rec_t;

    // trace control states
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_run   = 2'd1,
        st_drain = 2'd2
    } trace_state_t;

endpackage

/* trace_table.sv */
////////////////////
// trace table
// per-tag instruction word and stage entry stamps,
// record assembly as the instruction enters write-back
////////////////////

`timescale 1ns/1ps

module trace_table import trace_pkg::*; #(
    parameter int ID_W    = 3,
    parameter int CYCLE_W = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [CYCLE_W-1:0]              now,
    input  logic [instr_w-1:0]              fetch_instr,
    input  logic [num_stages-1:0]           stage_valid,
    input  logic [num_stages-1:0][ID_W-1:0] stage_tag,
    input  logic                            wb_done,
    output logic                            rec_push,
    output trace_rec_t                      rec_data
);

    localparam int num_entries = 2 ** ID_W;

    // storage, indexed by tag
    logic [instr_w-1:0] instr_mem [num_entries];
    // fetch..memory stamps, write-back comes straight from now
    logic [CYCLE_W-1:0] stamp_mem [num_entries][num_stages-1];

    // last cycle's view of each stage, spots a held stage
    logic [num_stages-1:0]           prev_valid;
    logic [num_stages-1:0][ID_W-1:0] prev_tag;
    logic [num_stages-1:0]           stage_new;
    logic [ID_W-1:0]                 wb_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_valid <= '0;
        end else begin
            prev_valid <= stage_valid;
        end
    end

    always_ff @(posedge clk) begin
        prev_tag <= stage_tag;
    end

    // same tag in the same stage twice running means it was held
    // in-flight tags are distinct, so no false hold match
    always_comb begin
        for (int s = 0; s < num_stages; s++) begin
            stage_new[s] = stage_valid[s] && !(prev_valid[s] && (prev_tag[s] == stage_tag[s]));
        end
    end

    ////////////////////
    // stamp capture
    ////////////////////

    always_ff @(posedge clk) begin
        // word is captured with the fetch stamp
        if (stage_new[stg_fetch]) begin
            instr_mem[stage_tag[stg_fetch]] <= fetch_instr;
        end
        for (int s = 0; s < num_stages - 1; s++) begin
            if (stage_new[s]) begin
                stamp_mem[stage_tag[s]][s] <= now;
            end
        end
    end

    ////////////////////
    // record assembly
    ////////////////////

    assign wb_tag   = stage_tag[stg_wb];
    // one push per instruction, on its write-back entry cycle
    assign rec_push = wb_done && stage_new[stg_wb];

    always_comb begin
        rec_data.id            = wb_tag;
        rec_data.instr         = instr_mem[wb_tag];
        rec_data.fetch_cycle   = stamp_mem[wb_tag][stg_fetch];
        rec_data.decode_cycle  = stamp_mem[wb_tag][stg_decode];
        rec_data.execute_cycle = stamp_mem[wb_tag][stg_execute];
        rec_data.memory_cycle  = stamp_mem[wb_tag][stg_memory];
        // memory stamp was written last cycle, wb stamp is this one
        rec_data.wb_cycle      = now;
    end

endmodule
